// File: rtl/axil_bridge_macros.svh
// the core widths must be at least the AXI widths and MEM_WORDS must be a power of two
`ifndef AXIL_BRIDGE_MACROS_SVH
`define AXIL_BRIDGE_MACROS_SVH

// axi4-lite side
`define AXIL_AW 16
`define AXIL_DW 32
// one strobe bit per data byte
`define AXIL_SW (`AXIL_DW / 8)

// core load/store port
`define CORE_AW 32
`define CORE_DW 32
// byte enables on the core side
`define CORE_BW (`CORE_DW / 8)

// sram depth in words
`define MEM_WORDS 256

`endif

// File: rtl/axil_bridge_pkg.sv
// response and state encodings only, the widths live in the macro header
package axil_bridge_pkg;

  // axi response codes, bit 1 set means an error
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // bridge sequencer, one axi transaction per core request
  typedef enum logic [3:0] {
    IDLE,
    READ_START,
    AR_HANDSHAKE,
    R_HANDSHAKE,
    READ_END,
    WRITE_START,
    AW_HANDSHAKE,
    W_HANDSHAKE,
    WRITE_END
  } bridge_state_e;

endpackage : axil_bridge_pkg

// File: rtl/axil_mem_subsys.sv
// core port with one request at a time and fixed 4 cycle latency from req_i to rvalid_o
`timescale 1ns/1ps

`include "axil_bridge_macros.svh"

module axil_mem_subsys (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  input  logic                  we_i,
  input  logic [`CORE_BW-1:0]   be_i,
  input  logic [`CORE_AW-1:0]   addr_i,
  input  logic [`CORE_DW-1:0]   wdata_i,
  output logic [`CORE_DW-1:0]   rdata_o,
  output logic                  err_o
);

  // axi4-lite link between bridge and sram
  logic [`AXIL_AW-1:0] aw_addr;
  logic                aw_valid;
  logic                aw_ready;
  logic [`AXIL_DW-1:0] w_data;
  logic [`AXIL_SW-1:0] w_strb;
  logic                w_valid;
  logic                w_ready;
  logic [1:0]          b_resp;
  logic                b_valid;
  logic                b_ready;
  logic [`AXIL_AW-1:0] ar_addr;
  logic                ar_valid;
  logic                ar_ready;
  logic [`AXIL_DW-1:0] r_data;
  logic [1:0]          r_resp;
  logic                r_valid;
  logic                r_ready;

  mem_axil_bridge u_bridge (
    .clk_i, .rst_ni,
    .req_i, .gnt_o, .rvalid_o, .we_i, .be_i, .addr_i, .wdata_i, .rdata_o, .err_o,
    .aw_addr_o (aw_addr), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
    .w_data_o  (w_data),  .w_strb_o   (w_strb),   .w_valid_o  (w_valid),
    .w_ready_i (w_ready),
    .b_resp_i  (b_resp),  .b_valid_i  (b_valid),  .b_ready_o  (b_ready),
    .ar_addr_o (ar_addr), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
    .r_data_i  (r_data),  .r_resp_i   (r_resp),   .r_valid_i  (r_valid),
    .r_ready_o (r_ready)
  );

  axil_sram_slave u_sram (
    .clk_i, .rst_ni,
    .aw_addr_i (aw_addr), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_data_i  (w_data),  .w_strb_i   (w_strb),   .w_valid_i  (w_valid),
    .w_ready_o (w_ready),
    .b_resp_o  (b_resp),  .b_valid_o  (b_valid),  .b_ready_i  (b_ready),
    .ar_addr_i (ar_addr), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .r_data_o  (r_data),  .r_resp_o   (r_resp),   .r_valid_o  (r_valid),
    .r_ready_i (r_ready)
  );

endmodule : axil_mem_subsys

// File: rtl/axil_sram_slave.sv
// accepts aw and w only in the same cycle and addresses from MEM_WORDS*4 upward get SLVERR
`timescale 1ns/1ps

`include "axil_bridge_macros.svh"

module axil_sram_slave
  import axil_bridge_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // write address and data
  input  logic [`AXIL_AW-1:0]   aw_addr_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  logic [`AXIL_DW-1:0]   w_data_i,
  input  logic [`AXIL_SW-1:0]   w_strb_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  // write response
  output axi_resp_e             b_resp_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  // read address and data
  input  logic [`AXIL_AW-1:0]   ar_addr_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output logic [`AXIL_DW-1:0]   r_data_o,
  output axi_resp_e             r_resp_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  localparam int idx_w = $clog2(`MEM_WORDS);

  logic [`AXIL_DW-1:0] mem_q [`MEM_WORDS];

  // control state
  logic r_valid_q;
  logic b_valid_q;
  logic wr_pend_q;   // accepted write waiting for commit

  // payload
  logic [`AXIL_DW-1:0] r_data_q;
  axi_resp_e           r_resp_q;
  axi_resp_e           b_resp_q;
  logic [idx_w-1:0]    wr_idx_q;
  logic [`AXIL_DW-1:0] wr_data_q;
  logic [`AXIL_SW-1:0] wr_strb_q;
  logic                wr_ok_q;

  logic busy;
  logic rd_accept;
  logic wr_accept;

  function automatic logic in_range(input logic [`AXIL_AW-1:0] addr);
    return 32'(addr) < 32'(`MEM_WORDS * 4);
  endfunction

  assign busy       = wr_pend_q | b_valid_q | r_valid_q;
  assign ar_ready_o = ~busy;
  assign rd_accept  = ar_valid_i & ar_ready_o;
  // both write channels in one go, a concurrent read wins
  assign wr_accept  = ~busy & aw_valid_i & w_valid_i & ~ar_valid_i;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      if (rd_accept) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      wr_pend_q <= wr_accept;  // single cycle stage
      if (wr_pend_q) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_resp_q <= in_range(ar_addr_i) ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= in_range(ar_addr_i) ? mem_q[ar_addr_i[idx_w+1:2]] : '0;
    end
    if (wr_accept) begin
      wr_ok_q   <= in_range(aw_addr_i);
      wr_idx_q  <= aw_addr_i[idx_w+1:2];  // byte address to word index
      wr_data_q <= w_data_i;
      wr_strb_q <= w_strb_i;
    end
    if (wr_pend_q) begin
      b_resp_q <= wr_ok_q ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // commit stage, only strobed bytes change
  always_ff @(posedge clk_i) begin
    if (wr_pend_q && wr_ok_q) begin
      for (int i = 0; i < `AXIL_SW; i++) begin
        if (wr_strb_q[i]) begin
          mem_q[wr_idx_q][i*8 +: 8] <= wr_data_q[i*8 +: 8];
        end
      end
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;
  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;

endmodule : axil_sram_slave

// File: rtl/mem_axil_bridge.sv
// one AXI4-Lite transaction in flight and core request fields must stay stable until gnt_o
`timescale 1ns/1ps

`include "axil_bridge_macros.svh"

module mem_axil_bridge
  import axil_bridge_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core side
  input  logic                  req_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  input  logic                  we_i,
  input  logic [`CORE_BW-1:0]   be_i,
  input  logic [`CORE_AW-1:0]   addr_i,
  input  logic [`CORE_DW-1:0]   wdata_i,
  output logic [`CORE_DW-1:0]   rdata_o,
  output logic                  err_o,
  // write address channel
  output logic [`AXIL_AW-1:0]   aw_addr_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  // write data channel
  output logic [`AXIL_DW-1:0]   w_data_o,
  output logic [`AXIL_SW-1:0]   w_strb_o,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  // write response channel
  input  logic [1:0]            b_resp_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  // read address channel
  output logic [`AXIL_AW-1:0]   ar_addr_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  // read data channel
  input  logic [`AXIL_DW-1:0]   r_data_i,
  input  logic [1:0]            r_resp_i,
  input  logic                  r_valid_i,
  output logic                  r_ready_o
);

  bridge_state_e state_q, state_d;

  logic err_q;        // bit 1 of the last axi response
  logic rdata_load;   // r transfer this cycle
  logic resp_load;    // r or b transfer this cycle
  logic resp_err;

  // core byte enables map straight onto the strobes
  assign w_strb_o = be_i[`AXIL_SW-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rdata_o <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rdata_load) begin
        rdata_o <= `CORE_DW'(r_data_i);  // zero extended when the core is wider
      end
      if (resp_load) begin
        err_q <= resp_err;
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    gnt_o      = 1'b0;
    rvalid_o   = 1'b0;
    err_o      = 1'b0;
    aw_addr_o  = '0;
    aw_valid_o = 1'b0;
    w_data_o   = '0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    ar_addr_o  = '0;
    ar_valid_o = 1'b0;
    r_ready_o  = 1'b0;
    rdata_load = 1'b0;
    resp_load  = 1'b0;
    resp_err   = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = we_i ? WRITE_START : READ_START;
        end
      end

      // read path
      READ_START: begin
        ar_addr_o  = addr_i[`AXIL_AW-1:0];  // upper core bits dropped
        ar_valid_o = 1'b1;
        if (ar_ready_i) begin
          state_d = AR_HANDSHAKE;
        end
      end
      AR_HANDSHAKE: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          rdata_load = 1'b1;
          resp_load  = 1'b1;
          resp_err   = r_resp_i[1];
          state_d    = R_HANDSHAKE;
        end
      end
      R_HANDSHAKE: begin
        gnt_o   = 1'b1;
        state_d = READ_END;
      end
      READ_END: begin
        rvalid_o = 1'b1;
        err_o    = err_q;
        state_d  = IDLE;
      end

      // write path, aw and w offered together
      WRITE_START: begin
        aw_addr_o  = addr_i[`AXIL_AW-1:0];
        aw_valid_o = 1'b1;
        w_data_o   = wdata_i[`AXIL_DW-1:0];
        w_valid_o  = 1'b1;
        if (aw_ready_i && w_ready_i) begin
          state_d = W_HANDSHAKE;
        end else if (aw_ready_i) begin
          state_d = AW_HANDSHAKE;  // w still owed
        end
      end
      AW_HANDSHAKE: begin
        w_data_o  = wdata_i[`AXIL_DW-1:0];
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          state_d = W_HANDSHAKE;
        end
      end
      W_HANDSHAKE: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          gnt_o     = 1'b1;
          resp_load = 1'b1;
          resp_err  = b_resp_i[1];
          state_d   = WRITE_END;
        end
      end
      WRITE_END: begin
        rvalid_o = 1'b1;
        err_o    = err_q;
        state_d  = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule : mem_axil_bridge

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_axil_mem_subsys -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$out"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: tb.f
+incdir+rtl
rtl/axil_bridge_pkg.sv
rtl/mem_axil_bridge.sv
rtl/axil_sram_slave.sv
rtl/axil_mem_subsys.sv
verif/tb_axil_mem_subsys.sv

// File: verif/tb_axil_mem_subsys.sv
// single requester on falling edges and bytes never written are left out of read compares
`timescale 1ns/1ps

`include "axil_bridge_macros.svh"

module tb_axil_mem_subsys
  import axil_bridge_pkg::*;
();

  localparam int     n_ops       = 200;
  localparam int     n_dir       = 8;   // directed ops ahead of the random run
  localparam int     max_wait    = 8;   // cycles allowed for gnt_o
  localparam longint watchdog_ns = longint'(n_ops * 8 + 3) * 100;

  logic                clk;
  logic                rst_n;
  logic                req;
  logic                gnt;
  logic                rvalid;
  logic                we;
  logic [`CORE_BW-1:0] be;
  logic [`CORE_AW-1:0] addr;
  logic [`CORE_DW-1:0] wdata;
  logic [`CORE_DW-1:0] rdata;
  logic                err;

  // byte granular reference copy of the sram
  logic [`AXIL_DW-1:0] shadow_mem [`MEM_WORDS];
  logic [`AXIL_SW-1:0] shadow_known [`MEM_WORDS];

  logic [31:0] lfsr_q;

  axil_mem_subsys u_axil_mem_subsys (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (req),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .we_i     (we),
    .be_i     (be),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .rdata_o  (rdata),
    .err_o    (err)
  );

  always #50 clk = ~clk;  // 100 ns period

  // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [`CORE_DW-1:0] byte_mask(input logic [`CORE_BW-1:0] b);
    logic [`CORE_DW-1:0] m;
    for (int i = 0; i < `CORE_BW; i++) begin
      m[i*8 +: 8] = {8{b[i]}};
    end
    return m;
  endfunction

  // the slave only sees the low AXIL_AW address bits
  function automatic logic hits_sram(input logic [`CORE_AW-1:0] a);
    return 32'(a[`AXIL_AW-1:0]) < `MEM_WORDS * 4;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // one core request that returns at the falling edge of the rvalid_o cycle
  task automatic do_access(input logic wr, input logic [`CORE_AW-1:0] a,
                           input logic [`CORE_DW-1:0] d, input logic [`CORE_BW-1:0] b);
    int                  cycles;
    logic                in_rng;
    int unsigned         idx;
    logic [`CORE_DW-1:0] m;
    logic [`CORE_DW-1:0] exp_data;
    axi_resp_e           exp_resp;
    bridge_state_e       st;

    in_rng   = hits_sram(a);
    idx      = 32'(a[`AXIL_AW-1:2]);
    exp_resp = in_rng ? RESP_OKAY : RESP_SLVERR;

    @(negedge clk);
    req    = 1'b1;
    we     = wr;
    addr   = a;
    wdata  = d;
    be     = b;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      assert (!rvalid) else abort_run("rvalid_o rose before gnt_o");
    end while (!gnt && cycles < max_wait);
    st = u_axil_mem_subsys.u_bridge.state_q;
    assert (gnt)
      else abort_run($sformatf("no gnt_o within %0d cycles, bridge stuck in %s",
                               max_wait, st.name()));
    assert (cycles == 3)
      else abort_run($sformatf("gnt_o came %0d cycles after the request instead of 3", cycles));

    @(negedge clk);
    req = 1'b0;  // gnt_o was seen at the last rising edge
    assert (rvalid) else abort_run("rvalid_o missing one cycle after gnt_o");
    assert (err === !in_rng)
      else abort_run($sformatf("MISMATCH err_o got %h expected %h (%s) addr %08h",
                               err, !in_rng, exp_resp.name(), a));

    if (wr) begin
      if (in_rng) begin
        m                 = byte_mask(b);
        shadow_mem[idx]   = (shadow_mem[idx] & ~m) | (d & m);
        shadow_known[idx] = shadow_known[idx] | b;
      end
    end else begin
      if (in_rng) begin
        m        = byte_mask(shadow_known[idx]);
        exp_data = shadow_mem[idx];
      end else begin
        m        = '1;
        exp_data = '0;  // slverr reads come back as zero
      end
      assert ((rdata & m) === (exp_data & m))
        else abort_run($sformatf("MISMATCH rdata_o got %08h expected %08h mask %08h addr %08h",
                                 rdata, exp_data, m, a));
    end
  endtask

  // handshake ordering on the core port
  assert property (@(posedge clk) disable iff (!rst_n) gnt |-> req)
    else abort_run("gnt_o high with no request pending");
  assert property (@(posedge clk) disable iff (!rst_n) gnt |=> rvalid)
    else abort_run("rvalid_o did not follow gnt_o");
  assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> $past(gnt))
    else abort_run("rvalid_o high without gnt_o in the cycle before");
  assert property (@(posedge clk) disable iff (!rst_n) err |-> rvalid)
    else abort_run("err_o high outside a response cycle");

  initial begin
    #watchdog_ns;
    abort_run($sformatf("watchdog expired after %0d ns, the DUT stopped answering",
                        watchdog_ns));
  end

  initial begin
    logic [`CORE_AW-1:0] a;
    logic [`CORE_DW-1:0] d;
    logic [`CORE_BW-1:0] b;
    logic                wr;
    int unsigned         w;

    clk      = 1'b0;
    rst_n    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    be       = '0;
    addr     = '0;
    wdata    = '0;
    lfsr_q   = 32'h7eb2_097c;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow_mem[i]   = '0;
      shadow_known[i] = '0;
    end

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // quiet outputs before the first request
    repeat (2) begin
      assert (!gnt && !rvalid && !err)
        else abort_run("gnt_o, rvalid_o or err_o not low after reset");
      assert (rdata === '0)
        else abort_run($sformatf("MISMATCH rdata_o got %08h expected 00000000 after reset",
                                 rdata));
      @(negedge clk);
    end

    // directed full and partial writes, out of range and address truncation
    do_access(1'b1, 32'h0000_0014, 32'hcafe_f00d, 4'hf);
    do_access(1'b0, 32'h0000_0014, '0, 4'h0);
    do_access(1'b1, 32'h0000_0014, 32'h1234_5678, 4'b0101);
    do_access(1'b0, 32'h0000_0014, '0, 4'h0);
    do_access(1'b0, `MEM_WORDS * 4 + 32'h14, '0, 4'h0);
    do_access(1'b1, `MEM_WORDS * 4 + 32'h14, 32'hdead_beef, 4'hf);
    do_access(1'b0, 32'h0000_0014, '0, 4'h0);   // word 5 must be untouched
    do_access(1'b0, 32'h0001_0014, '0, 4'h0);   // aliases word 5

    // random back-to-back traffic
    repeat (n_ops - n_dir) begin
      wr = rand_bits(1) != 0;
      if (rand_bits(3) == 0) begin
        w = `MEM_WORDS + rand_bits(10);  // past the end of the sram
      end else begin
        w = rand_bits(4) * 17;           // small pool so reads land on written words
      end
      a = rand_bits(`CORE_AW - `AXIL_AW) << `AXIL_AW;
      a = a | (w << 2);
      d = rand_bits(`CORE_DW);
      b = `CORE_BW'(rand_bits(`CORE_BW));
      do_access(wr, a, d, b);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule : tb_axil_mem_subsys
